//--- src/pix_pkg.sv
// shared widths, luma weights and buffer depths; RGB888 only, weights sum to 256 so luma fits a sample
package pix_pkg;

    // one colour sample
    localparam int QUAN_BITS = 8;

    // input word carries two samples, a pixel three
    localparam int WORD_W = 2 * QUAN_BITS;
    localparam int PIX_W  = 3 * QUAN_BITS;

    // BT.601 style weights scaled by 256
    localparam logic [QUAN_BITS-1:0] LUMA_R_W = 8'd77;
    localparam logic [QUAN_BITS-1:0] LUMA_G_W = 8'd150;
    localparam logic [QUAN_BITS-1:0] LUMA_B_W = 8'd29;

    // buffer depths
    localparam int IN_DEPTH  = 8;
    localparam int OUT_DEPTH = 4;

    // payload of the output buffer, luma in the upper byte
    typedef struct packed {
        logic [QUAN_BITS-1:0] luma;
        logic [PIX_W-1:0]     pix;
    } pix_luma_t;

endpackage

//--- src/stream_fifo.sv
// first-word-fall-through FIFO; DEPTH of 1 or more, any packed payload_t, no storage reset
`timescale 1ns/1ps

module stream_fifo #(
    parameter type payload_t = logic [7:0],
    parameter int  DEPTH     = 4
) (
    input  logic     s_clk,
    input  logic     s_rst,
    // write side
    input  payload_t i_data,
    input  logic     i_in_valid,
    output logic     o_in_ready,
    // read side
    output payload_t o_data,
    output logic     o_out_valid,
    input  logic     i_out_ready
);

    localparam int AW = (DEPTH > 1) ? $clog2(DEPTH) : 1;
    localparam int CW = $clog2(DEPTH + 1);

    payload_t        mem [DEPTH];
    logic [AW-1:0]   wr_ptr;
    logic [AW-1:0]   rd_ptr;
    logic [CW-1:0]   count;
    logic            wr_en;
    logic            rd_en;

    assign o_in_ready  = (count != CW'(DEPTH));
    assign o_out_valid = (count != '0);
    assign o_data      = mem[rd_ptr];

    assign wr_en = i_in_valid & o_in_ready;
    assign rd_en = o_out_valid & i_out_ready;

    // storage
    always_ff @(posedge s_clk) begin
        if (wr_en) begin
            mem[wr_ptr] <= i_data;
        end
    end

    // pointers wrap at DEPTH, which need not be a power of two
    always_ff @(posedge s_clk or posedge s_rst) begin
        if (s_rst) begin
            wr_ptr <= '0;
            rd_ptr <= '0;
        end else begin
            if (wr_en) begin
                if (wr_ptr == AW'(DEPTH - 1)) begin
                    wr_ptr <= '0;
                end else begin
                    wr_ptr <= wr_ptr + 1'b1;
                end
            end
            if (rd_en) begin
                if (rd_ptr == AW'(DEPTH - 1)) begin
                    rd_ptr <= '0;
                end else begin
                    rd_ptr <= rd_ptr + 1'b1;
                end
            end
        end
    end

    // fill level
    always_ff @(posedge s_clk or posedge s_rst) begin
        if (s_rst) begin
            count <= '0;
        end else begin
            case ({wr_en, rd_en})
                2'b10:   count <= count + 1'b1;
                2'b01:   count <= count - 1'b1;
                default: count <= count;
            endcase
        end
    end

endmodule

//--- src/width_change.sv
// 16 to 24 bit unpacker; low byte first, red in pixel bits 7:0, input ready lags output ready by one cycle
`timescale 1ns/1ps

module width_change (
    input  logic                       s_clk,
    input  logic                       s_rst,
    // word side
    input  logic [pix_pkg::WORD_W-1:0] i_bytes_in,
    input  logic                       i_bytes_in_valid,
    output logic                       o_bytes_in_ready,
    // pixel side
    output logic [pix_pkg::PIX_W-1:0]  o_bytes_out,
    output logic                       o_bytes_out_valid,
    input  logic                       i_bytes_out_ready
);

    localparam int QB = pix_pkg::QUAN_BITS;
    localparam int WW = pix_pkg::WORD_W;
    localparam int PW = pix_pkg::PIX_W;

    logic [1:0]    r_cnt;
    logic [WW-1:0] r_bytes_in;
    logic [PW-1:0] r_bytes_out;
    logic          r_bytes_out_valid;
    logic [PW-1:0] r_buffer_data;
    logic          r_buffer_valid;
    logic [PW-1:0] pix_next;
    logic          in_fire;
    logic          pix_fire;
    logic          to_buffer;

    assign in_fire  = i_bytes_in_valid & o_bytes_in_ready;
    // phase 0 word only waits for its partner
    assign pix_fire = in_fire & (r_cnt != 2'd0);

    // pixel shown from the main register but not taken
    assign to_buffer = r_bytes_out_valid & ~r_buffer_valid & ~i_bytes_out_ready;

    // the hold buffer always carries the older pixel
    assign o_bytes_out_valid = r_buffer_valid | r_bytes_out_valid;
    assign o_bytes_out       = r_buffer_valid ? r_buffer_data : r_bytes_out;

    // {b, g, r}
    always_comb begin
        if (r_cnt == 2'd1) begin
            pix_next = {i_bytes_in[QB-1:0], r_bytes_in};
        end else begin
            pix_next = {i_bytes_in, r_bytes_in[WW-1:QB]};
        end
    end

    // registered copy of downstream ready
    always_ff @(posedge s_clk or posedge s_rst) begin
        if (s_rst) begin
            o_bytes_in_ready <= 1'b0;
        end else begin
            o_bytes_in_ready <= i_bytes_out_ready;
        end
    end

    // three word phase
    always_ff @(posedge s_clk or posedge s_rst) begin
        if (s_rst) begin
            r_cnt <= 2'd0;
        end else if (in_fire) begin
            if (r_cnt == 2'd2) begin
                r_cnt <= 2'd0;
            end else begin
                r_cnt <= r_cnt + 1'b1;
            end
        end
    end

    always_ff @(posedge s_clk) begin
        if (in_fire) begin
            r_bytes_in <= i_bytes_in;
        end
        if (pix_fire) begin
            r_bytes_out <= pix_next;
        end
        if (to_buffer) begin
            r_buffer_data <= r_bytes_out;
        end
    end

    // main pixel leaves when taken or parked; it stays while the buffer is ahead of it
    always_ff @(posedge s_clk or posedge s_rst) begin
        if (s_rst) begin
            r_bytes_out_valid <= 1'b0;
        end else if (pix_fire) begin
            r_bytes_out_valid <= 1'b1;
        end else if (!r_buffer_valid) begin
            r_bytes_out_valid <= 1'b0;
        end
    end

    // hold buffer
    always_ff @(posedge s_clk or posedge s_rst) begin
        if (s_rst) begin
            r_buffer_valid <= 1'b0;
        end else if (r_buffer_valid) begin
            if (i_bytes_out_ready) begin
                r_buffer_valid <= 1'b0;
            end
        end else if (to_buffer) begin
            r_buffer_valid <= 1'b1;
        end
    end

endmodule

//--- src/rgb_to_luma.sv
// luma = (77r + 150g + 29b) >> 8, two cycle latency, whole pipe stalls while output is held
`timescale 1ns/1ps

module rgb_to_luma (
    input  logic                          s_clk,
    input  logic                          s_rst,
    // pixel in
    input  logic [pix_pkg::PIX_W-1:0]     i_pix,
    input  logic                          i_pix_valid,
    output logic                          o_pix_ready,
    // pixel and luma out
    output logic [pix_pkg::PIX_W-1:0]     o_pix,
    output logic [pix_pkg::QUAN_BITS-1:0] o_luma,
    output logic                          o_out_valid,
    input  logic                          i_luma_ready
);

    localparam int QB     = pix_pkg::QUAN_BITS;
    localparam int PW     = pix_pkg::PIX_W;
    localparam int PROD_W = 2 * QB;

    logic              en;
    logic              s1_valid;
    logic [PW-1:0]     s1_pix;
    logic [PROD_W-1:0] s1_prod_r;
    logic [PROD_W-1:0] s1_prod_g;
    logic [PROD_W-1:0] s1_prod_b;
    logic [PROD_W-1:0] luma_sum;

    // advance when the output slot is free or being emptied
    assign en          = i_luma_ready | ~o_out_valid;
    assign o_pix_ready = en;

    // weights add up to 256, so the sum cannot overflow
    assign luma_sum = s1_prod_r + s1_prod_g + s1_prod_b;

    always_ff @(posedge s_clk or posedge s_rst) begin
        if (s_rst) begin
            s1_valid    <= 1'b0;
            o_out_valid <= 1'b0;
        end else if (en) begin
            s1_valid    <= i_pix_valid;
            o_out_valid <= s1_valid;
        end
    end

    // stage one, weighted samples
    always_ff @(posedge s_clk) begin
        if (en) begin
            s1_pix    <= i_pix;
            s1_prod_r <= i_pix[QB-1:0] * pix_pkg::LUMA_R_W;
            s1_prod_g <= i_pix[2*QB-1:QB] * pix_pkg::LUMA_G_W;
            s1_prod_b <= i_pix[3*QB-1:2*QB] * pix_pkg::LUMA_B_W;
        end
    end

    // stage two, sum and scale
    always_ff @(posedge s_clk) begin
        if (en) begin
            o_pix  <= s1_pix;
            o_luma <= luma_sum[PROD_W-1:QB];
        end
    end

endmodule

//--- src/pixel_unpack_top.sv
// word stream in, {luma, pixel} out; one clock, depths from the package, no frame or line markers
`timescale 1ns/1ps

module pixel_unpack_top (
    input  logic                          s_clk,
    input  logic                          s_rst,
    // packed words from the bus
    input  logic [pix_pkg::WORD_W-1:0]    i_word,
    input  logic                          i_word_valid,
    output logic                          o_word_ready,
    // unpacked pixels to the sink
    output logic [pix_pkg::PIX_W-1:0]     o_pix,
    output logic [pix_pkg::QUAN_BITS-1:0] o_luma,
    output logic                          o_pix_valid,
    input  logic                          i_pix_ready
);

    // input buffer to converter
    logic [pix_pkg::WORD_W-1:0]    fifo_word;
    logic                          fifo_word_valid;
    logic                          conv_in_ready;

    // converter to luma stage
    logic [pix_pkg::PIX_W-1:0]     conv_pix;
    logic                          conv_pix_valid;
    logic                          luma_in_ready;

    // luma stage to output buffer
    logic [pix_pkg::PIX_W-1:0]     luma_pix;
    logic [pix_pkg::QUAN_BITS-1:0] luma_val;
    logic                          luma_valid;
    logic                          out_fifo_ready;

    pix_pkg::pix_luma_t            luma_pair;
    pix_pkg::pix_luma_t            out_pair;

    assign luma_pair = {luma_val, luma_pix};
    assign o_pix     = out_pair.pix;
    assign o_luma    = out_pair.luma;

    stream_fifo #(
        .payload_t (logic [pix_pkg::WORD_W-1:0]),
        .DEPTH     (pix_pkg::IN_DEPTH)
    ) u_in_fifo (
        .s_clk       (s_clk),
        .s_rst       (s_rst),
        .i_data      (i_word),
        .i_in_valid  (i_word_valid),
        .o_in_ready  (o_word_ready),
        .o_data      (fifo_word),
        .o_out_valid (fifo_word_valid),
        .i_out_ready (conv_in_ready)
    );

    width_change u_width_change (
        .s_clk             (s_clk),
        .s_rst             (s_rst),
        .i_bytes_in        (fifo_word),
        .i_bytes_in_valid  (fifo_word_valid),
        .o_bytes_in_ready  (conv_in_ready),
        .o_bytes_out       (conv_pix),
        .o_bytes_out_valid (conv_pix_valid),
        .i_bytes_out_ready (luma_in_ready)
    );

    rgb_to_luma u_rgb_to_luma (
        .s_clk        (s_clk),
        .s_rst        (s_rst),
        .i_pix        (conv_pix),
        .i_pix_valid  (conv_pix_valid),
        .o_pix_ready  (luma_in_ready),
        .o_pix        (luma_pix),
        .o_luma       (luma_val),
        .o_out_valid  (luma_valid),
        .i_luma_ready (out_fifo_ready)
    );

    stream_fifo #(
        .payload_t (pix_pkg::pix_luma_t),
        .DEPTH     (pix_pkg::OUT_DEPTH)
    ) u_out_fifo (
        .s_clk       (s_clk),
        .s_rst       (s_rst),
        .i_data      (luma_pair),
        .i_in_valid  (luma_valid),
        .o_in_ready  (out_fifo_ready),
        .o_data      (out_pair),
        .o_out_valid (o_pix_valid),
        .i_out_ready (i_pix_ready)
    );

endmodule

//--- sim/pixel_unpack_properties.sv
// handshake checks for width_change, bound to every instance; reset must be high at the first clock edge
`timescale 1ns/1ps

module pixel_unpack_properties (
    input logic                      s_clk,
    input logic                      s_rst,
    input logic [pix_pkg::PIX_W-1:0] o_bytes_out,
    input logic                      o_bytes_out_valid,
    input logic                      i_bytes_out_ready,
    input logic                      o_bytes_in_ready
);

    // raised by any failing assertion, watched by the testbench
    bit fail_seen = 1'b0;

    // a pixel that is not taken stays offered
    property p_valid_held;
        @(posedge s_clk) disable iff (s_rst)
        (o_bytes_out_valid && !i_bytes_out_ready) |=> o_bytes_out_valid;
    endproperty

    // and its value does not move
    property p_data_held;
        @(posedge s_clk) disable iff (s_rst)
        (o_bytes_out_valid && !i_bytes_out_ready) |=> $stable(o_bytes_out);
    endproperty

    // nothing offered or accepted while in reset
    property p_quiet_in_reset;
        @(posedge s_clk) s_rst |-> (!o_bytes_out_valid && !o_bytes_in_ready);
    endproperty

    a_valid_held: assert property (p_valid_held) else begin
        $error("width_change dropped valid while its pixel was not taken");
        fail_seen = 1'b1;
    end

    a_data_held: assert property (p_data_held) else begin
        $error("width_change changed a pixel that was waiting to be taken");
        fail_seen = 1'b1;
    end

    a_quiet_in_reset: assert property (p_quiet_in_reset) else begin
        $error("width_change handshake active during reset");
        fail_seen = 1'b1;
    end

endmodule

bind width_change pixel_unpack_properties u_wc_props (
    .s_clk             (s_clk),
    .s_rst             (s_rst),
    .o_bytes_out       (o_bytes_out),
    .o_bytes_out_valid (o_bytes_out_valid),
    .i_bytes_out_ready (i_bytes_out_ready),
    .o_bytes_in_ready  (o_bytes_in_ready)
);

//--- sim/tb_pixel_unpack.sv
// testbench for pixel_unpack_top; 3000 random words, sink ready in phases, stops at the first mismatch
`timescale 1ns/1ps

module tb_pixel_unpack;

    localparam int N_WORDS   = 3000;
    localparam int N_PIX     = N_WORDS * 2 / 3;
    localparam int CLK_NS    = 4;
    localparam int RST_CYC   = 5;
    localparam int PHASE_LEN = 400;
    localparam int DRAIN_CYC = 40;
    localparam int QB        = pix_pkg::QUAN_BITS;

    logic                      s_clk;
    logic                      s_rst;
    logic [pix_pkg::WORD_W-1:0] i_word;
    logic                      i_word_valid;
    logic                      o_word_ready;
    logic [pix_pkg::PIX_W-1:0] o_pix;
    logic [QB-1:0]             o_luma;
    logic                      o_pix_valid;
    logic                      i_pix_ready;

    integer        seed;
    logic [QB-1:0] byte_q [$];
    int            words_accepted;
    int            pix_seen;
    int            cycle;
    // input side backed up while the sink was held off
    logic          saw_stall;

    pixel_unpack_top uut (
        .s_clk        (s_clk),
        .s_rst        (s_rst),
        .i_word       (i_word),
        .i_word_valid (i_word_valid),
        .o_word_ready (o_word_ready),
        .o_pix        (o_pix),
        .o_luma       (o_luma),
        .o_pix_valid  (o_pix_valid),
        .i_pix_ready  (i_pix_ready)
    );

    // weighted sum of the three samples scaled back by 256
    function automatic logic [QB-1:0] luma_ref(input logic [pix_pkg::PIX_W-1:0] pix);
        int r;
        int g;
        int b;
        int sum;
        r   = int'(pix[QB-1:0]);
        g   = int'(pix[2*QB-1:QB]);
        b   = int'(pix[3*QB-1:2*QB]);
        sum = r * int'(pix_pkg::LUMA_R_W) + g * int'(pix_pkg::LUMA_G_W)
            + b * int'(pix_pkg::LUMA_B_W);
        return QB'(sum >> 8);
    endfunction

    task automatic check_equal(input logic [31:0] got, input logic [31:0] exp,
                               input string what);
        if (got !== exp) begin
            $display("Error at %0t ns: %s, got %0h, expected %0h", $time, what, got, exp);
            $display("Errors found");
            $fatal(1, "mismatch in %s", what);
        end
    endtask

    initial begin
        s_clk = 1'b0;
        forever #(CLK_NS / 2) s_clk = ~s_clk;
    end

    initial begin
        #(N_WORDS * CLK_NS * 20);
        $display("Errors found");
        $fatal(1, "timeout, only %0d of %0d pixels arrived", pix_seen, N_PIX);
    end

    // stimulus and byte model
    initial begin : drive_proc
        logic [31:0] rnd;
        logic [31:0] data;
        seed           = 32'hb315_afcd;
        s_rst          = 1'b0;
        i_word         = '0;
        i_word_valid   = 1'b0;
        i_pix_ready    = 1'b0;
        words_accepted = 0;
        saw_stall      = 1'b0;
        cycle          = 0;
        // reset rises just after time zero, ahead of the first clock edge
        #1;
        s_rst = 1'b1;
        repeat (RST_CYC) @(posedge s_clk);
        s_rst <= 1'b0;
        while (pix_seen < N_PIX) begin
            @(posedge s_clk);
            if (i_word_valid && o_word_ready) begin
                byte_q.push_back(i_word[QB-1:0]);
                byte_q.push_back(i_word[2*QB-1:QB]);
                words_accepted++;
            end
            if (!o_word_ready && !i_pix_ready) begin
                saw_stall = 1'b1;
            end
            // a word not yet taken stays as it is
            if (!i_word_valid || o_word_ready) begin
                rnd  = $random(seed);
                data = $random(seed);
                if (words_accepted < N_WORDS) begin
                    i_word_valid <= ((rnd % 10) < 7);
                    i_word       <= data[pix_pkg::WORD_W-1:0];
                end else begin
                    i_word_valid <= 1'b0;
                end
            end
            // sink runs always ready, then coin toss, then long low bursts
            rnd = $random(seed);
            case ((cycle / PHASE_LEN) % 3)
                0:       i_pix_ready <= 1'b1;
                1:       i_pix_ready <= rnd[0];
                default: i_pix_ready <= ((cycle % 100) >= 70) && rnd[1];
            endcase
            cycle++;
        end
        // open the sink so any extra pixel would show up
        i_pix_ready <= 1'b1;
        repeat (DRAIN_CYC) @(posedge s_clk);
        check_equal(32'(o_pix_valid), 32'd0, "o_pix_valid after the last pixel");
        check_equal(32'(saw_stall), 32'd1, "o_word_ready falling under back-pressure");
        check_equal(32'(uut.u_width_change.u_wc_props.fail_seen), 32'd0,
                    "width_change handshake assertions");
        $display("No errors");
        $finish;
    end

    // compare every output transfer with the next three bytes
    initial pix_seen = 0;

    always @(posedge s_clk) begin : compare_proc
        logic [pix_pkg::PIX_W-1:0] exp_pix;
        check_equal(32'(uut.u_width_change.u_wc_props.fail_seen), 32'd0,
                    "width_change handshake assertions");
        if (s_rst || words_accepted == 0) begin
            check_equal(32'(o_pix_valid), 32'd0, "o_pix_valid before any accepted word");
        end else if (o_pix_valid && i_pix_ready) begin
            check_equal(32'(byte_q.size() >= 3), 32'd1, "pixel without three accepted bytes");
            exp_pix = {byte_q[2], byte_q[1], byte_q[0]};
            void'(byte_q.pop_front());
            void'(byte_q.pop_front());
            void'(byte_q.pop_front());
            check_equal(32'(o_pix), 32'(exp_pix), "o_pix");
            check_equal(32'(o_luma), 32'(luma_ref(exp_pix)), "o_luma");
            pix_seen++;
        end
    end

endmodule

//--- build.f
src/pix_pkg.sv
src/stream_fifo.sv
src/width_change.sv
src/rgb_to_luma.sv
src/pixel_unpack_top.sv
sim/pixel_unpack_properties.sv
sim/tb_pixel_unpack.sv
